// File: icache_pkg.sv
package icache_pkg;

	// ==========================================================================
	// Cache geometry
	// ==========================================================================

	// Byte address width of the fetch port
	localparam int AWID = 32;
	// Four ways, each with 128 lines of 64 bytes
	localparam int WAYS = 4;
	localparam int LINES = 128;
	localparam int LINE_BITS = 512;
	localparam int WORD_BITS = 32;
	localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

	// Address split into line offset, index and tag
	localparam int OFS_BITS = 6;
	localparam int IDX_BITS = 7;
	localparam int BYTE_BITS = 2;
	localparam int WSEL_BITS = OFS_BITS - BYTE_BITS;
	// The tag is everything above the line offset, so it also covers the index bits
	localparam int TAG_BITS = AWID - OFS_BITS;
	localparam int WAY_BITS = $clog2(WAYS);

	// ==========================================================================
	// Types
	// ==========================================================================

	// Way number within a set
	typedef logic [WAY_BITS-1:0] way_t;

	// Controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		CHECK,
		MISS_REQ,
		MISS_WAIT,
		FILL
	} icache_state_e;

	// Fetch byte address, bits 31 to 6 are the tag and bits 5 to 2 pick the word
	typedef struct packed {
		logic [TAG_BITS-1:0]  tag;
		logic [WSEL_BITS-1:0] wsel;
		logic [BYTE_BITS-1:0] ofs;
	} fetch_addr_t;

	// One line write into tag store, data store and replacement counters
	typedef struct packed {
		logic                 valid;
		way_t                 way;
		logic [IDX_BITS-1:0]  idx;
		logic [TAG_BITS-1:0]  tag;
		logic [LINE_BITS-1:0] data;
	} fill_t;

	// The set index sits in the low bits of the tag, address bits 12 to 6
	function automatic logic [IDX_BITS-1:0] line_idx(fetch_addr_t a);
		return a.tag[IDX_BITS-1:0];
	endfunction

endpackage

// File: icache_tag_store.sv
module icache_tag_store import icache_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                flush,
	input  fetch_addr_t         addr,
	input  fill_t               fill,
	output logic [TAG_BITS-1:0] way_tags [WAYS],
	output logic [WAYS-1:0]     way_valid
);

	// ==========================================================================
	// Storage
	// ==========================================================================

	// Full tag per line per way
	logic [TAG_BITS-1:0] tag_mem [WAYS][LINES];
	// One valid bit per line, grouped by way so flush can clear a way at once
	logic [LINES-1:0]    valid_q [WAYS];
	// Set selected by the current request
	logic [IDX_BITS-1:0] idx;

	assign idx = line_idx(addr);

	// Tags are written on a fill and never cleared
	always_ff @(posedge clk)
	begin
		if (fill.valid)
			tag_mem[fill.way][fill.idx] <= fill.tag;
	end

	// Valid bits drop on reset and on flush
	// A fill marks its line valid
	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			for (int w = 0; w < WAYS; w++)
				valid_q[w] <= '0;
		end
		else if (fill.valid)
		begin
			valid_q[fill.way][fill.idx] <= 1'b1;
		end
	end

	// ==========================================================================
	// Read port
	// ==========================================================================

	// All four ways are read at the request index in the same cycle
	// While a fill is being written, its tag is forwarded to the read side
	// This lets the hit detector see the new line in the FILL cycle already,
	// which gives it the two matching cycles it needs before the next CHECK
	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
		begin
			way_tags[w] = tag_mem[w][idx];
			way_valid[w] = valid_q[w][idx];
			if (fill.valid && fill.way == way_t'(w) && fill.idx == idx)
			begin
				way_tags[w] = fill.tag;
				way_valid[w] = 1'b1;
			end
		end
	end

endmodule

// File: icache_hit_detect.sv
module icache_hit_detect import icache_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  fetch_addr_t         addr,
	input  logic [TAG_BITS-1:0] way_tags [WAYS],
	input  logic [WAYS-1:0]     way_valid,
	output logic                hit,
	output way_t                way
);

	// Per-way compare result of the current cycle
	logic [WAYS-1:0] match;
	// Way selected in the previous cycle, held when nothing matches
	way_t            way_q;
	// Any-match flag of the previous cycle
	logic            match_q;

	// ==========================================================================
	// Tag compare
	// ==========================================================================

	// Each way compares its tag to the request tag
	// A line that is not valid can never match
	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
			match[w] = way_valid[w] && (way_tags[w] == addr.tag);
	end

	// Way select, scanning upwards so the highest matching way wins
	// With no match the output keeps the last way that was selected
	always_comb
	begin
		way = way_q;
		for (int w = 0; w < WAYS; w++)
		begin
			if (match[w])
				way = way_t'(w);
		end
	end

	// ==========================================================================
	// Hit qualification
	// ==========================================================================

	// The hit flag needs a match in two consecutive cycles
	// A single cycle of match right after the address changes is not enough,
	// so a hit never comes from a tag that belonged to the previous address
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			way_q <= '0;
			match_q <= 1'b0;
			hit <= 1'b0;
		end
		else
		begin
			way_q <= way;
			match_q <= |match;
			hit <= match_q & (|match);
		end
	end

endmodule

// File: icache_replace.sv
module icache_replace import icache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  fetch_addr_t addr,
	input  fill_t       fill,
	output way_t        victim
);

	// ==========================================================================
	// Round-robin victim counters
	// ==========================================================================

	// One two-bit counter per set, pointing at the next way to replace
	way_t rr_q [LINES];

	// Counters start at way 0 after reset
	// A flush leaves them alone, so refills continue the rotation
	// On a fill the counter moves one past the way that was just written
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < LINES; i++)
				rr_q[i] <= '0;
		end
		else if (fill.valid)
		begin
			// Wraps from way 3 back to way 0
			rr_q[fill.idx] <= way_t'(fill.way + 1'b1);
		end
	end

	// The victim is the counter of the set being looked up
	assign victim = rr_q[line_idx(addr)];

endmodule

// File: icache_data_store.sv
module icache_data_store import icache_pkg::*; (
	input  logic                 clk,
	input  fetch_addr_t          addr,
	input  way_t                 way,
	input  fill_t                fill,
	output logic [WORD_BITS-1:0] word
);

	// ==========================================================================
	// Line storage
	// ==========================================================================

	// Whole 64-byte lines for every way and set
	logic [LINE_BITS-1:0] line_mem [WAYS][LINES];

	// Indexed line of the selected way
	logic [LINE_BITS-1:0] rd_line;
	// The same line viewed as sixteen instruction words
	logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] rd_words;

	// A fill always writes a complete line
	always_ff @(posedge clk)
	begin
		if (fill.valid)
			line_mem[fill.way][fill.idx] <= fill.data;
	end

	// ==========================================================================
	// Word read
	// ==========================================================================

	assign rd_line = line_mem[way][line_idx(addr)];
	assign rd_words = rd_line;

	// Word 0 is in the low 32 bits of the line
	assign word = rd_words[addr.wsel];

endmodule

// File: icache_ctrl.sv
module icache_ctrl import icache_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 fetch_req,
	input  logic                 flush_in,
	input  logic [AWID-1:0]      fetch_addr,
	input  logic                 hit,
	input  way_t                 way,
	input  way_t                 victim,
	input  logic                 mem_ack,
	input  logic [LINE_BITS-1:0] mem_line,
	output fetch_addr_t          addr,
	output fill_t                fill,
	output logic                 flush,
	output logic                 mem_req,
	output logic [AWID-1:0]      mem_addr,
	output logic                 resp_valid,
	output logic                 busy,
	output way_t                 resp_way
);

	icache_state_e        state;
	icache_state_e        state_nxt;
	// Address of the request being served
	fetch_addr_t          addr_q;
	// Line returned by memory, held for the FILL cycle
	logic [LINE_BITS-1:0] line_q;
	logic                 busy_q;
	logic                 idle;
	logic                 accept;

	// ==========================================================================
	// Request acceptance
	// ==========================================================================

	// Busy stays high through the response cycle, so idle also covers it
	assign idle = (state == IDLE) && !busy_q;
	// Requests that arrive while busy are dropped
	assign accept = fetch_req && idle;
	// Flush is passed on only between requests
	assign flush = flush_in && idle;
	assign busy = busy_q;

	// The new address goes straight to the datapath in the accept cycle
	// That starts the tag compare one cycle early, so the hit is qualified by CHECK
	assign addr = accept ? fetch_addr_t'(fetch_addr) : addr_q;

	// ==========================================================================
	// State machine
	// ==========================================================================

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:      if (accept) state_nxt = LOOKUP;
			LOOKUP:    state_nxt = CHECK;
			CHECK:     state_nxt = hit ? IDLE : MISS_REQ;
			MISS_REQ:  state_nxt = MISS_WAIT;
			MISS_WAIT: if (mem_ack) state_nxt = FILL;
			// After the write the lookup runs again and now hits
			FILL:      state_nxt = LOOKUP;
			default:   state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			busy_q <= 1'b0;
			resp_valid <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// The response goes out in the cycle after a hitting CHECK
			resp_valid <= (state == CHECK) && hit;
			if (accept)
				busy_q <= 1'b1;
			else if (resp_valid)
				busy_q <= 1'b0;
		end
	end

	// Request address and returned line are payload only
	always_ff @(posedge clk)
	begin
		if (accept)
			addr_q <= fetch_addr_t'(fetch_addr);
		if (state == MISS_WAIT && mem_ack)
			line_q <= mem_line;
		// Way that hit, reported together with resp_valid
		if (state == CHECK)
			resp_way <= way;
	end

	// ==========================================================================
	// Miss handling
	// ==========================================================================

	// One memory request per miss, for the line-aligned address
	assign mem_req = (state == MISS_REQ);
	assign mem_addr = {addr_q.tag, {OFS_BITS{1'b0}}};

	// The fill goes into the way chosen by the round-robin counter of the set
	always_comb
	begin
		fill.valid = (state == FILL);
		fill.way = victim;
		fill.idx = line_idx(addr_q);
		fill.tag = addr_q.tag;
		fill.data = line_q;
	end

endmodule

// File: icache_top.sv
module icache_top import icache_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 fetch_req,
	input  logic [AWID-1:0]      fetch_addr,
	input  logic                 flush,
	input  logic                 mem_ack,
	input  logic [LINE_BITS-1:0] mem_line,
	output logic                 resp_valid,
	output logic [WORD_BITS-1:0] resp_data,
	output way_t                 resp_way,
	output logic                 busy,
	output logic                 mem_req,
	output logic [AWID-1:0]      mem_addr
);

	// ==========================================================================
	// Internal connections
	// ==========================================================================

	fetch_addr_t         addr;
	fill_t               fill;
	// Flush after the controller has checked that no request is in flight
	logic                flush_clr;
	logic [TAG_BITS-1:0] way_tags [WAYS];
	logic [WAYS-1:0]     way_valid;
	logic                hit;
	way_t                hit_way;
	way_t                victim;

	// Sequencing of lookup, miss request, fill and response
	icache_ctrl icache_ctrl_inst (
		.clk        (clk),
		.rst        (rst),
		.fetch_req  (fetch_req),
		.flush_in   (flush),
		.fetch_addr (fetch_addr),
		.hit        (hit),
		.way        (hit_way),
		.victim     (victim),
		.mem_ack    (mem_ack),
		.mem_line   (mem_line),
		.addr       (addr),
		.fill       (fill),
		.flush      (flush_clr),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.resp_valid (resp_valid),
		.busy       (busy),
		.resp_way   (resp_way)
	);

	icache_tag_store icache_tag_store_inst (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush_clr),
		.addr      (addr),
		.fill      (fill),
		.way_tags  (way_tags),
		.way_valid (way_valid)
	);

	icache_hit_detect icache_hit_detect_inst (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.way_tags  (way_tags),
		.way_valid (way_valid),
		.hit       (hit),
		.way       (hit_way)
	);

	icache_replace icache_replace_inst (
		.clk    (clk),
		.rst    (rst),
		.addr   (addr),
		.fill   (fill),
		.victim (victim)
	);

	// The word is read from the way registered with the response
	icache_data_store icache_data_store_inst (
		.clk  (clk),
		.addr (addr),
		.way  (resp_way),
		.fill (fill),
		.word (resp_data)
	);

endmodule

// File: icache_properties.sv
module icache_properties import icache_pkg::*; (
	input logic          clk,
	input logic          rst,
	input icache_state_e state,
	input logic          mem_req,
	input logic          mem_ack,
	input logic          resp_valid,
	input logic          busy,
	input logic          fill_valid
);

	// ==========================================================================
	// Controller protocol properties
	// ==========================================================================

	// Number of failed properties, read back at the end of the run
	int fail_count = 0;

	// One request pulse per miss
	mem_req_pulse: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
	else
	begin
		fail_count++;
		$error("mem_req stayed high for more than one cycle");
	end

	// The response cycle finds the FSM back in IDLE with busy still high
	resp_closes_request: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> state == IDLE && busy)
	else
	begin
		fail_count++;
		$error("resp_valid outside a request in flight");
	end

	// Memory latency in this environment never exceeds 20 cycles
	ack_in_time: assert property (@(posedge clk) disable iff (rst) mem_req |-> ##[1:24] mem_ack)
	else
	begin
		fail_count++;
		$error("mem_ack did not follow mem_req in time");
	end

	fill_one_cycle: assert property (@(posedge clk) disable iff (rst) fill_valid |=> !fill_valid)
	else
	begin
		fail_count++;
		$error("fill was valid for more than one cycle");
	end

endmodule

bind icache_ctrl icache_properties icache_properties_inst (
	.clk        (clk),
	.rst        (rst),
	.state      (state),
	.mem_req    (mem_req),
	.mem_ack    (mem_ack),
	.resp_valid (resp_valid),
	.busy       (busy),
	.fill_valid (fill.valid)
);

// File: icache_tb.sv
module icache_tb import icache_pkg::*; ();

	// ==========================================================================
	// Stimulus table
	// ==========================================================================

	typedef enum logic {
		OP_FETCH,
		OP_FLUSH
	} op_e;

	// One row: operation, byte address, memory latency, expected miss and way
	typedef struct packed {
		op_e         op;
		logic [31:0] addr;
		logic [7:0]  lat;
		logic        miss;
		way_t        way;
	} row_t;

	localparam int NROWS = 19;
	localparam int RESP_TIMEOUT = 100;
	localparam int QUIET_CYCLES = 4;

	// Rows 2 to 8 share set 5, rows 0, 1 and 10 share set 65
	// The last rows sweep the memory latency from 1 to 20 cycles
	row_t stim [NROWS] = '{
		'{OP_FETCH, 32'h0000_1040, 8'd3,  1'b1, 2'd0},
		'{OP_FETCH, 32'h0000_1048, 8'd0,  1'b0, 2'd0},
		'{OP_FETCH, 32'h0001_0140, 8'd2,  1'b1, 2'd0},
		'{OP_FETCH, 32'h0002_0144, 8'd4,  1'b1, 2'd1},
		'{OP_FETCH, 32'h0003_0148, 8'd5,  1'b1, 2'd2},
		'{OP_FETCH, 32'h0004_014c, 8'd6,  1'b1, 2'd3},
		'{OP_FETCH, 32'h0005_0150, 8'd8,  1'b1, 2'd0},
		'{OP_FETCH, 32'h0002_017c, 8'd0,  1'b0, 2'd1},
		'{OP_FETCH, 32'h0001_0144, 8'd9,  1'b1, 2'd1},
		'{OP_FLUSH, 32'h0000_0000, 8'd0,  1'b0, 2'd0},
		'{OP_FETCH, 32'h0000_1044, 8'd10, 1'b1, 2'd1},
		'{OP_FETCH, 32'h0003_0158, 8'd11, 1'b1, 2'd2},
		'{OP_FETCH, 32'h0003_015c, 8'd0,  1'b0, 2'd2},
		'{OP_FETCH, 32'h1234_5680, 8'd1,  1'b1, 2'd0},
		'{OP_FETCH, 32'h00ab_c7c4, 8'd7,  1'b1, 2'd0},
		'{OP_FETCH, 32'h0f0f_0a08, 8'd13, 1'b1, 2'd0},
		'{OP_FETCH, 32'h8000_1ffc, 8'd20, 1'b1, 2'd0},
		'{OP_FETCH, 32'h8000_1fc0, 8'd0,  1'b0, 2'd0},
		'{OP_FETCH, 32'h1234_56bc, 8'd0,  1'b0, 2'd0}
	};

	logic                 clk;
	logic                 rst;
	logic                 fetch_req;
	logic [AWID-1:0]      fetch_addr;
	logic                 flush;
	logic                 mem_ack;
	logic [LINE_BITS-1:0] mem_line;
	logic                 resp_valid;
	logic [WORD_BITS-1:0] resp_data;
	way_t                 resp_way;
	logic                 busy;
	logic                 mem_req;
	logic [AWID-1:0]      mem_addr;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int prop_fails = 0;
	int cur_lat = 0;
	int seed = 32'h5a87_8794;
	bit abort = 0;

	// Reference model state: tag copy, valid bit and round-robin pointer per set
	logic [TAG_BITS-1:0] ref_tag [WAYS][LINES];
	logic                ref_valid [WAYS][LINES];
	way_t                ref_rr [LINES];

	icache_top icache_top_inst (
		.clk        (clk),
		.rst        (rst),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.flush      (flush),
		.mem_ack    (mem_ack),
		.mem_line   (mem_line),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.resp_way   (resp_way),
		.busy       (busy),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==========================================================================
	// Memory model and reference model
	// ==========================================================================

	// Word k of a line is the line address with k in the low bits
	initial
	begin
		logic [AWID-1:0] line_addr;
		mem_ack = 1'b0;
		mem_line = '0;
		forever
		begin
			@(negedge clk);
			if (mem_req === 1'b1)
			begin
				line_addr = mem_addr;
				repeat (cur_lat) @(posedge clk);
				#1;
				for (int k = 0; k < LINE_BITS / WORD_BITS; k++)
					mem_line[k*WORD_BITS +: WORD_BITS] = line_addr | k;
				mem_ack = 1'b1;
				@(posedge clk);
				#1;
				mem_ack = 1'b0;
			end
		end
	end

	// Highest matching valid way hits, otherwise the set pointer picks the victim
	function automatic void model_fetch(input logic [31:0] a, output logic miss, output way_t w);
		int idx;
		logic [TAG_BITS-1:0] tag;
		idx = a[12:6];
		tag = a[31:6];
		miss = 1'b1;
		w = ref_rr[idx];
		for (int i = 0; i < WAYS; i++)
		begin
			if (ref_valid[i][idx] && ref_tag[i][idx] == tag)
			begin
				miss = 1'b0;
				w = way_t'(i);
			end
		end
		if (miss)
		begin
			ref_tag[w][idx] = tag;
			ref_valid[w][idx] = 1'b1;
			ref_rr[idx] = way_t'(w + 1);
		end
	endfunction

	function automatic void model_clear(input bit pointers);
		for (int l = 0; l < LINES; l++)
		begin
			for (int i = 0; i < WAYS; i++)
				ref_valid[i][l] = 1'b0;
			if (pointers)
				ref_rr[l] = '0;
		end
	endfunction

	// ==========================================================================
	// Row execution
	// ==========================================================================

	task automatic check_value(input int r, input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("Error at %0t in row %0d: %s expected 0x%0h, got 0x%0h",
				$time, r, name, exp, act);
		end
	endtask

	// Neither a response nor a memory request may show up while idle
	task automatic watch_quiet(input int r);
		repeat (QUIET_CYCLES)
		begin
			@(negedge clk);
			checks++;
			assert (resp_valid === 1'b0 && mem_req === 1'b0)
			else
			begin
				errors++;
				$display("Unexpected response or memory request after row %0d at %0t", r, $time);
			end
		end
		check_value(r, "busy", 32'd0, busy);
	endtask

	task automatic apply_flush(input int r);
		model_clear(1'b0);
		@(posedge clk);
		#1;
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		watch_quiet(r);
	endtask

	task automatic apply_fetch(input int r);
		logic [31:0] a;
		logic m_miss;
		way_t m_way;
		int cycles;
		int reqs;
		bit got;
		logic [31:0] got_data;
		way_t got_way;
		logic got_busy;
		a = stim[r].addr;
		cur_lat = stim[r].lat;
		model_fetch(a, m_miss, m_way);
		checks++;
		assert (m_miss == stim[r].miss && m_way == stim[r].way)
		else
		begin
			errors++;
			$display("Row %0d of the table disagrees with the reference model", r);
		end
		cycles = 0;
		reqs = 0;
		got = 0;
		@(posedge clk);
		#1;
		fetch_req = 1'b1;
		fetch_addr = a;
		while (!got && cycles < RESP_TIMEOUT)
		begin
			@(negedge clk);
			if (mem_req)
			begin
				reqs++;
				check_value(r, "mem_addr", {a[31:6], 6'b0}, mem_addr);
			end
			if (resp_valid)
			begin
				got = 1;
				got_data = resp_data;
				got_way = resp_way;
				got_busy = busy;
			end
			else
				cycles++;
			@(posedge clk);
			#1;
			// Stray requests on every busy cycle, the response cycle included,
			// which the cache must drop
			if (!got && busy === 1'b1)
			begin
				fetch_req = 1'b1;
				fetch_addr = $random(seed);
			end
			else
				fetch_req = 1'b0;
		end
		fetch_req = 1'b0;
		if (!got)
		begin
			errors++;
			timeouts++;
			abort = 1;
			$display("Timeout: no resp_valid within %0d cycles in row %0d", RESP_TIMEOUT, r);
		end
		else
		begin
			check_value(r, "resp_data", {a[31:6], 6'b0} | a[5:2], got_data);
			check_value(r, "resp_way", stim[r].way, got_way);
			check_value(r, "mem_req pulses", stim[r].miss ? 32'd1 : 32'd0, reqs);
			// Busy is still high in the response cycle
			check_value(r, "busy", 32'd1, got_busy);
			// Hits answer in a fixed three cycles
			if (!stim[r].miss)
				check_value(r, "resp_valid latency", 32'd3, cycles);
			watch_quiet(r);
		end
	endtask

	initial
	begin
		rst = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		model_clear(1'b1);
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_value(-1, "resp_valid", 32'd0, resp_valid);
		check_value(-1, "mem_req", 32'd0, mem_req);
		check_value(-1, "busy", 32'd0, busy);
		for (int r = 0; r < NROWS && !abort; r++)
		begin
			if (stim[r].op == OP_FLUSH)
				apply_flush(r);
			else
				apply_fetch(r);
		end
		prop_fails = icache_top_inst.icache_ctrl_inst.icache_properties_inst.fail_count;
		$display("Checks: %0d, errors: %0d, timeouts: %0d, property failures: %0d",
			checks, errors, timeouts, prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: src.f
icache_pkg.sv
icache_tag_store.sv
icache_hit_detect.sv
icache_replace.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
icache_properties.sv
icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - icache_pkg.sv
      - icache_tag_store.sv
      - icache_hit_detect.sv
      - icache_replace.sv
      - icache_data_store.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    files:
      - icache_properties.sv
      - icache_tb.sv
